// File: common/memPortIf.sv
`timescale 1ns/1ps
`default_nettype none

// Dual-port memory bus between the FIFO and its RAM
interface memPortIf import pktBufPkg::*; #(
    parameter int ADDR_WID = 5
) ();

    // Write port, one entry per cycle
    logic                 wEn;
    logic [ADDR_WID-1:0]  wAddr;
    logic [ENTRY_WID-1:0] wData;

    // Read port, the data follows the address by one cycle
    logic [ADDR_WID-1:0]  rAddr;
    logic [ENTRY_WID-1:0] rData;

    // The FIFO owns the addresses and the write strobe
    modport fifo (
        output wEn, wAddr, wData, rAddr,
        input  rData
    );

    // The RAM only returns read data
    modport ram (
        input  wEn, wAddr, wData, rAddr,
        output rData
    );

endinterface

`default_nettype wire

// File: common/pktBufPkg.sv
`default_nettype none

package pktBufPkg;

    // One frame byte as it appears on the receive and transmit ports
    localparam int BYTE_WID = 8;

    // A stored entry is the byte with the frame's last flag on top
    localparam int ENTRY_WID = BYTE_WID + 1;

    // Position of the last flag inside a stored entry
    localparam int LAST_BIT = ENTRY_WID - 1;

    // States of the transmit sequencer
    // TX_IDLE waits for a committed frame
    // TX_SEND pops and sends the bytes of one frame
    // TX_WAIT_ACK holds the frame until the far end answers
    typedef enum logic [1:0] {
        TX_IDLE     = 2'd0,
        TX_SEND     = 2'd1,
        TX_WAIT_ACK = 2'd2
    } txState_t;

endpackage

`default_nettype wire

// File: design/pktBufTop.sv
`timescale 1ns/1ps
`default_nettype none

module pktBufTop import pktBufPkg::*; #(
    parameter int ADDR_WID = 5,
    parameter int ENTRIES  = 24
) (
    input  wire logic                clk_i,
    input  wire logic                rstN_i,
    input  wire logic                rxValid_i,
    input  wire logic [BYTE_WID-1:0] rxData_i,
    input  wire logic                rxLast_i,
    output logic                     rxFull_o,
    output logic                     txValid_o,
    output logic [BYTE_WID-1:0]      txData_o,
    output logic                     txLast_o,
    input  wire logic                txAck_i,
    input  wire logic                txNack_i,
    output logic [7:0]               dropCount_o
);

    // Receive path into the FIFO
    logic                 dataValid;
    logic [ENTRY_WID-1:0] rxEntry;
    logic                 frameEnd, frameOk;
    logic                 fillTransDone, fillTransSuccess;

    // FIFO out to the transmit path
    logic                 popData, dataAvailable;
    logic [ENTRY_WID-1:0] txEntry;
    logic                 popTransDone, popTransSuccess;
    logic                 sendEn, txLastSent;

    memPortIf #(.ADDR_WID(ADDR_WID)) memBus ();

    rxChecker u_rxChecker (
        .clk_i, .rstN_i, .rxValid_i, .rxData_i, .rxLast_i,
        .full_i(rxFull_o), .dataValid_o(dataValid), .data_o(rxEntry),
        .frameEnd_o(frameEnd), .frameOk_o(frameOk)
    );

    pktCtrl u_pktCtrl (
        .clk_i, .rstN_i, .frameEnd_i(frameEnd), .frameOk_i(frameOk),
        .fillTransDone_o(fillTransDone), .fillTransSuccess_o(fillTransSuccess),
        .dataAvailable_i(dataAvailable), .sendEn_o(sendEn), .txLastSent_i(txLastSent),
        .txAck_i, .txNack_i, .popTransDone_o(popTransDone),
        .popTransSuccess_o(popTransSuccess), .dropCount_o
    );

    transFifo #(.ADDR_WID(ADDR_WID), .ENTRIES(ENTRIES)) u_transFifo (
        .clk_i, .rstN_i, .mem(memBus.fifo),
        .fillTransDone_i(fillTransDone), .fillTransSuccess_i(fillTransSuccess),
        .dataValid_i(dataValid), .data_i(rxEntry), .full_o(rxFull_o),
        .popTransDone_i(popTransDone), .popTransSuccess_i(popTransSuccess),
        .popData_i(popData), .dataAvailable_o(dataAvailable), .data_o(txEntry)
    );

    dualPortRam #(.ADDR_WID(ADDR_WID), .ENTRIES(ENTRIES)) u_dualPortRam (
        .clk_i, .mem(memBus.ram)
    );

    txSender u_txSender (
        .clk_i, .rstN_i, .sendEn_i(sendEn), .dataAvailable_i(dataAvailable),
        .popData_o(popData), .data_i(txEntry), .txValid_o, .txData_o, .txLast_o,
        .txLastSent_o(txLastSent)
    );

endmodule

`default_nettype wire

// File: design/pktCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module pktCtrl import pktBufPkg::*; (
    input  wire logic clk_i,
    input  wire logic rstN_i,

    // Receive side frame verdicts
    input  wire logic frameEnd_i,
    input  wire logic frameOk_i,
    output logic      fillTransDone_o,
    output logic      fillTransSuccess_o,

    // Transmit sequencing
    input  wire logic dataAvailable_i,
    output logic      sendEn_o,
    input  wire logic txLastSent_i,
    input  wire logic txAck_i,
    input  wire logic txNack_i,
    output logic      popTransDone_o,
    output logic      popTransSuccess_o,

    output logic [7:0] dropCount_o
);

    txState_t state, nextState;
    logic     answer;

    // A frame end closes the fill transaction in the same cycle
    assign fillTransDone_o    = frameEnd_i;
    assign fillTransSuccess_o = frameOk_i;

    // Only an answer to a frame on the line counts
    assign answer            = (state == TX_WAIT_ACK) && (txAck_i || txNack_i);
    assign popTransDone_o    = answer;
    // An acknowledge wins if both arrive together
    assign popTransSuccess_o = txAck_i;

    assign sendEn_o = state == TX_SEND;

    always_comb begin
        nextState = state;
        unique case (state)
            TX_IDLE: begin
                if (dataAvailable_i) begin
                    nextState = TX_SEND;
                end
            end
            TX_SEND: begin
                if (txLastSent_i) begin
                    nextState = TX_WAIT_ACK;
                end
            end
            TX_WAIT_ACK: begin
                if (answer) begin
                    nextState = TX_IDLE;
                end
            end
            default: nextState = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            state       <= TX_IDLE;
            dropCount_o <= '0;
        end else begin
            state <= nextState;
            // Counter wraps at 8 bits
            if (frameEnd_i && !frameOk_i) begin
                dropCount_o <= dropCount_o + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/rxChecker.sv
`timescale 1ns/1ps
`default_nettype none

module rxChecker import pktBufPkg::*; (
    input  wire logic                 clk_i,
    input  wire logic                 rstN_i,
    input  wire logic                 rxValid_i,
    input  wire logic [BYTE_WID-1:0]  rxData_i,
    input  wire logic                 rxLast_i,
    input  wire logic                 full_i,
    output logic                      dataValid_o,
    output logic [ENTRY_WID-1:0]      data_o,
    output logic                      frameEnd_o,
    output logic                      frameOk_o
);

    // Running XOR of the frame so far and the sticky lost-byte flag
    logic [BYTE_WID-1:0] checksum;
    logic                overflow;
    logic [BYTE_WID-1:0] nextChecksum;
    logic                nextOverflow;

    // Each byte goes straight to the FIFO tagged with its last flag
    assign data_o      = {rxLast_i, rxData_i};
    // A byte offered against a full buffer is lost
    assign dataValid_o = rxValid_i && !full_i;

    // Fold in the current byte, written or not
    assign nextChecksum = checksum ^ rxData_i;
    assign nextOverflow = overflow || full_i;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            checksum   <= '0;
            overflow   <= 1'b0;
            frameEnd_o <= 1'b0;
        end else begin
            frameEnd_o <= rxValid_i && rxLast_i;
            if (rxValid_i) begin
                if (rxLast_i) begin
                    // Start the next frame from a clean state
                    checksum <= '0;
                    overflow <= 1'b0;
                end else begin
                    checksum <= nextChecksum;
                    overflow <= nextOverflow;
                end
            end
        end
    end

    // The verdict is only sampled together with frameEnd_o
    always_ff @(posedge clk_i) begin
        if (rxValid_i && rxLast_i) begin
            frameOk_o <= (nextChecksum == '0) && !nextOverflow;
        end
    end

endmodule

`default_nettype wire

// File: design/txSender.sv
`timescale 1ns/1ps
`default_nettype none

module txSender import pktBufPkg::*; (
    input  wire logic                 clk_i,
    input  wire logic                 rstN_i,
    input  wire logic                 sendEn_i,
    input  wire logic                 dataAvailable_i,
    output logic                      popData_o,
    input  wire logic [ENTRY_WID-1:0] data_i,
    output logic                      txValid_o,
    output logic [BYTE_WID-1:0]       txData_o,
    output logic                      txLast_o,
    output logic                      txLastSent_o
);

    // Pop phase, flips every cycle while sending is enabled
    logic popPhase;
    // A popped entry is due from the RAM in this cycle
    logic pending;
    // The last entry of the frame has come back, no more pops
    logic frameDone;

    // Pops land on every second cycle, which also leaves room to see the last flag
    assign popData_o = sendEn_i && dataAvailable_i && popPhase && !frameDone;

    // The last byte on the line marks the frame as fully sent
    assign txLastSent_o = txLast_o;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            popPhase  <= 1'b0;
            pending   <= 1'b0;
            frameDone <= 1'b0;
            txValid_o <= 1'b0;
            txLast_o  <= 1'b0;
        end else begin
            // Phase restarts with each send window so the first pop is immediate
            popPhase  <= sendEn_i ? !popPhase : 1'b1;
            pending   <= popData_o;
            txValid_o <= pending;
            txLast_o  <= pending && data_i[LAST_BIT];
            if (!sendEn_i) begin
                frameDone <= 1'b0;
            end else if (pending && data_i[LAST_BIT]) begin
                frameDone <= 1'b1;
            end
        end
    end

    // Outgoing byte, two cycles after its pop
    always_ff @(posedge clk_i) begin
        if (pending) begin
            txData_o <= data_i[BYTE_WID-1:0];
        end
    end

endmodule

`default_nettype wire

// File: pktBuf.f
common/pktBufPkg.sv
common/memPortIf.sv
transFifo/dualPortRam.sv
transFifo/transFifo.sv
design/rxChecker.sv
design/txSender.sv
design/pktCtrl.sv
design/pktBufTop.sv
verif/pktBufTb_assert.sv
verif/pktBufTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the packet buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pktBufTb -f pktBuf.f -o pktBufSim

# The run passes only if the pass message shows up on a line of its own
./obj_dir/pktBufSim | tee /dev/stderr | grep -qx "TESTS PASSED"

// File: transFifo/dualPortRam.sv
`timescale 1ns/1ps
`default_nettype none

module dualPortRam import pktBufPkg::*; #(
    parameter int ADDR_WID = 5,
    parameter int ENTRIES  = 24
) (
    input  wire logic clk_i,
    memPortIf.ram     mem
);

    // Storage has no reset, the FIFO pointers decide what is valid
    logic [ENTRY_WID-1:0] ram [ENTRIES];

    logic [ADDR_WID-1:0] wIdx, rIdx;

    assign wIdx = mem.wAddr;
    assign rIdx = mem.rAddr;

    // Synchronous write
    always_ff @(posedge clk_i) begin
        if (mem.wEn) begin
            ram[wIdx] <= mem.wData;
        end
    end

    // Registered read, so data shows up one cycle after its address
    // A read of the word being written returns the old contents
    always_ff @(posedge clk_i) begin
        mem.rData <= ram[rIdx];
    end

endmodule

`default_nettype wire

// File: transFifo/transFifo.sv
`timescale 1ns/1ps
`default_nettype none

module transFifo import pktBufPkg::*; #(
    parameter int ADDR_WID = 5,
    parameter int ENTRIES  = 24
) (
    input  wire logic                 clk_i,
    input  wire logic                 rstN_i,

    // Backing RAM
    memPortIf.fifo                    mem,

    // Fill side, a transaction end never shares a cycle with a write
    input  wire logic                 fillTransDone_i,
    input  wire logic                 fillTransSuccess_i,
    input  wire logic                 dataValid_i,
    input  wire logic [ENTRY_WID-1:0] data_i,
    output logic                      full_o,

    // Pop side, a transaction end never shares a cycle with a pop
    input  wire logic                 popTransDone_i,
    input  wire logic                 popTransSuccess_i,
    input  wire logic                 popData_i,
    output logic                      dataAvailable_o,
    output logic [ENTRY_WID-1:0]      data_o
);

    // Every pointer carries one extra wrap bit above the address
    logic [ADDR_WID:0] wrPtr, rdPtr;
    logic [ADDR_WID:0] transWrPtr, transRdPtr;
    logic [ADDR_WID:0] nextTransWrPtr, nextTransRdPtr;
    logic              writeHandshake, readHandshake;

    localparam logic [ADDR_WID-1:0] MAX_IDX = ADDR_WID'(ENTRIES - 1);

    // Full when the tentative writer has lapped the committed reader
    assign full_o = (transWrPtr[ADDR_WID] != rdPtr[ADDR_WID]) &&
                    (transWrPtr[ADDR_WID-1:0] == rdPtr[ADDR_WID-1:0]);

    // Only committed frames are visible to the reader
    assign dataAvailable_o = transRdPtr != wrPtr;

    assign writeHandshake = dataValid_i && !full_o;
    assign readHandshake  = popData_i && dataAvailable_o;

    // Both sides always address the RAM through their tentative pointers
    assign mem.wEn   = writeHandshake;
    assign mem.wAddr = transWrPtr[ADDR_WID-1:0];
    assign mem.wData = data_i;
    assign mem.rAddr = transRdPtr[ADDR_WID-1:0];
    // Read data lags the read address by one cycle
    assign data_o    = mem.rData;

    generate
        if (ENTRIES == 2**ADDR_WID) begin : gFullRange
            // The whole address space is backed, so plain overflow wraps correctly
            assign nextTransWrPtr = transWrPtr + 1'b1;
            assign nextTransRdPtr = transRdPtr + 1'b1;
        end else begin : gBoundedRange
            // Past the last word the address restarts at zero and the wrap bit flips
            assign nextTransWrPtr = (transWrPtr[ADDR_WID-1:0] == MAX_IDX) ?
                                    {~transWrPtr[ADDR_WID], {ADDR_WID{1'b0}}} :
                                    transWrPtr + 1'b1;
            assign nextTransRdPtr = (transRdPtr[ADDR_WID-1:0] == MAX_IDX) ?
                                    {~transRdPtr[ADDR_WID], {ADDR_WID{1'b0}}} :
                                    transRdPtr + 1'b1;
        end
    endgenerate

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            wrPtr      <= '0;
            transWrPtr <= '0;
            rdPtr      <= '0;
            transRdPtr <= '0;
        end else begin
            // A good frame is committed, a bad one is rolled back
            if (fillTransDone_i) begin
                if (fillTransSuccess_i) begin
                    wrPtr <= transWrPtr;
                end else begin
                    transWrPtr <= wrPtr;
                end
            end else if (writeHandshake) begin
                transWrPtr <= nextTransWrPtr;
            end

            // An acknowledged frame frees its space, a refused one is rewound
            if (popTransDone_i) begin
                if (popTransSuccess_i) begin
                    rdPtr <= transRdPtr;
                end else begin
                    transRdPtr <= rdPtr;
                end
            end else if (readHandshake) begin
                transRdPtr <= nextTransRdPtr;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/pktBufTb.sv
`timescale 1ns/1ps
`default_nettype none

module pktBufTb import pktBufPkg::*; ();

    localparam int NUM_FRAMES  = 40;
    localparam int MAX_PAYLOAD = 12;
    localparam int MAX_BYTES   = MAX_PAYLOAD + 1;
    // Depth of the buffer under test
    localparam int FIFO_ENTRIES = 24;
    // 40 frames of 13 bytes at 2 cycles a byte, 4 tries and 40 spare cycles each, rounded up
    localparam int TIMEOUT_CYCLES = 8000;

    logic                clk_i, rstN_i;
    logic                rxValid_i, rxLast_i, rxFull_o;
    logic [BYTE_WID-1:0] rxData_i, txData_o;
    logic                txValid_o, txLast_o, txAck_i, txNack_i;
    logic [7:0]          dropCount_o;

    // Receive stimulus, one frame is built ahead and then played out byte by byte
    logic [15:0]         lfsr;
    logic [BYTE_WID-1:0] frameBuf [MAX_BYTES];
    int                  rxTotal, rxPos, rxGap, framesBuilt, rxWritten;
    logic                rxLost, rxCorrupt;

    // Reference model, committed frames flattened into one byte queue with their lengths
    logic [BYTE_WID-1:0] expBytes [$];
    int                  expLens [$];
    int                  expDrops, overflowDrops, corruptDrops;
    int                  txIdx, ackWait, delivered, nackCount;
    logic                ackPending;
    int                  errCount, cycleCount;

    // Fill level from the tentative write side down to the committed read side
    // Changes take effect one cycle after the write or acknowledge and two after a frame end
    int                  fifoUsed, rollNow, rollNext, ackLen;
    logic                wrote, expFull;

    pktBufTop #(.ENTRIES(FIFO_ENTRIES)) u_pktBufTop (
        .clk_i, .rstN_i, .rxValid_i, .rxData_i, .rxLast_i, .rxFull_o,
        .txValid_o, .txData_o, .txLast_o, .txAck_i, .txNack_i, .dropCount_o
    );

    always #2 clk_i = ~clk_i;

    // Galois LFSR with taps for x^16+x^14+x^13+x^11+1, stepped once per bit taken
    function automatic int randBits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic buildFrame();
        int                  payloadLen;
        logic [BYTE_WID-1:0] sum;
        payloadLen = randBits(4) % MAX_PAYLOAD + 1;
        sum = '0;
        for (int i = 0; i < payloadLen; i++) begin
            frameBuf[i] = BYTE_WID'(randBits(BYTE_WID));
            sum ^= frameBuf[i];
        end
        // Roughly one frame in five gets a single flipped checksum bit
        rxCorrupt = randBits(4) < 3;
        if (rxCorrupt) begin
            sum ^= BYTE_WID'(1 << randBits(3));
        end
        frameBuf[payloadLen] = sum;
        rxTotal   = payloadLen + 1;
        rxPos     = 0;
        rxLost    = 1'b0;
        rxWritten = 0;
        framesBuilt++;
    endtask

    // Retire last cycle's writes and acknowledges and the rollback of two cycles ago
    task automatic trackFill();
        if (wrote) begin
            fifoUsed++;
        end
        fifoUsed = fifoUsed - rollNow - ackLen;
        rollNow  = rollNext;
        rollNext = 0;
        ackLen   = 0;
        wrote    = 1'b0;
        expFull  = fifoUsed == FIFO_ENTRIES;
        assert (rxFull_o == expFull) else begin
            $display("MISMATCH rxFull_o: got 0x%h, expected 0x%h with %0d entries held",
                     rxFull_o, expFull, fifoUsed);
            errCount++;
        end
    endtask

    task automatic rxStep();
        rxValid_i = 1'b0;
        rxLast_i  = 1'b0;
        if (rxGap > 0) begin
            rxGap--;
        end else begin
            if (rxPos == rxTotal && framesBuilt < NUM_FRAMES) begin
                buildFrame();
            end
            if (rxPos < rxTotal) begin
                rxValid_i = 1'b1;
                rxData_i  = frameBuf[rxPos];
                rxLast_i  = rxPos == rxTotal - 1;
                // A byte offered against a full buffer is lost along with its frame
                if (expFull) begin
                    rxLost = 1'b1;
                end else begin
                    wrote = 1'b1;
                    rxWritten++;
                end
                rxPos++;
                if (rxPos == rxTotal) begin
                    if (rxLost) begin
                        expDrops++;
                        overflowDrops++;
                        rollNext = rxWritten;
                    end else if (rxCorrupt) begin
                        expDrops++;
                        corruptDrops++;
                        rollNext = rxWritten;
                    end else begin
                        for (int i = 0; i < rxTotal; i++) begin
                            expBytes.push_back(frameBuf[i]);
                        end
                        expLens.push_back(rxTotal);
                    end
                    // At least one idle cycle, the commit lands there
                    rxGap = randBits(3) + 1;
                end
            end
        end
    endtask

    task automatic txStep();
        logic                inFrame;
        logic [BYTE_WID-1:0] expData;
        logic                expLast;
        txAck_i  = 1'b0;
        txNack_i = 1'b0;
        if (txValid_o) begin
            inFrame = expLens.size() > 0 && txIdx < expLens[0];
            assert (inFrame) else begin
                $display("transmit byte %0d came out with no committed frame left to match", txIdx);
                errCount++;
            end
            if (inFrame) begin
                expData = expBytes[txIdx];
                expLast = txIdx == expLens[0] - 1;
                assert (txData_o == expData) else begin
                    $display("MISMATCH txData_o: got 0x%h, expected 0x%h at byte %0d",
                             txData_o, expData, txIdx);
                    errCount++;
                end
                assert (txLast_o == expLast) else begin
                    $display("MISMATCH txLast_o: got 0x%h, expected 0x%h at byte %0d",
                             txLast_o, expLast, txIdx);
                    errCount++;
                end
            end
            txIdx++;
        end
        if (txValid_o && txLast_o) begin
            // The sequencer reaches its acknowledge wait one cycle after the last byte
            ackWait    = randBits(4) + 1;
            ackPending = 1'b1;
        end else if (ackPending) begin
            ackWait--;
            if (ackWait == 0) begin
                ackPending = 1'b0;
                txIdx      = 0;
                if (randBits(2) == 0) begin
                    // A refused frame must come back whole before anything newer
                    txNack_i = 1'b1;
                    nackCount++;
                end else begin
                    txAck_i = 1'b1;
                    delivered++;
                    if (expLens.size() > 0) begin
                        ackLen = expLens[0];
                        repeat (expLens[0]) begin
                            void'(expBytes.pop_front());
                        end
                        void'(expLens.pop_front());
                    end
                end
            end
        end
    endtask

    task automatic reportCounts();
        $display(
            "errors %0d, frames %0d, delivered %0d, dropped %0d (%0d full, %0d checksum), nacks %0d",
            errCount, framesBuilt, delivered, expDrops, overflowDrops, corruptDrops, nackCount);
    endtask

    always @(posedge clk_i) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d frames still waiting", cycleCount,
                     expLens.size());
            reportCounts();
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        clk_i       = 1'b0;
        rstN_i      = 1'b0;
        rxValid_i   = 1'b0;
        rxData_i    = '0;
        rxLast_i    = 1'b0;
        txAck_i     = 1'b0;
        txNack_i    = 1'b0;
        lfsr        = 16'd23;
        rxTotal     = 0;
        rxPos       = 0;
        rxGap       = 0;
        framesBuilt = 0;
        rxWritten   = 0;
        rxLost      = 1'b0;
        rxCorrupt   = 1'b0;
        expDrops    = 0;
        overflowDrops = 0;
        corruptDrops  = 0;
        txIdx       = 0;
        ackWait     = 0;
        ackPending  = 1'b0;
        delivered   = 0;
        nackCount   = 0;
        errCount    = 0;
        cycleCount  = 0;
        fifoUsed    = 0;
        rollNow     = 0;
        rollNext    = 0;
        ackLen      = 0;
        wrote       = 1'b0;
        expFull     = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rstN_i = 1'b1;
        // Run until every frame is offered and every committed one is acknowledged
        while (framesBuilt < NUM_FRAMES || rxPos < rxTotal ||
               expLens.size() > 0 || ackPending) begin
            @(negedge clk_i);
            trackFill();
            rxStep();
            txStep();
        end
        // Quiet time lets the last verdict reach the counter and exposes any stray frame
        repeat (20) begin
            @(negedge clk_i);
            trackFill();
            rxStep();
            txStep();
        end
        assert (dropCount_o == 8'(expDrops)) else begin
            $display("MISMATCH dropCount_o: got 0x%h, expected 0x%h", dropCount_o, 8'(expDrops));
            errCount++;
        end
        assert (overflowDrops > 0) else begin
            $display("no frame ever lost a byte to a full buffer");
            errCount++;
        end
        assert (nackCount > 0) else begin
            $display("no negative acknowledge was ever sent");
            errCount++;
        end
        reportCounts();
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/pktBufTb_assert.sv
`timescale 1ns/1ps
`default_nettype none

// Handshake rules of the transactional FIFO, watched at its own ports
module pktBufTb_assert (
    input wire logic clk_i,
    input wire logic rstN_i,
    input wire logic fillTransDone_i,
    input wire logic dataValid_i,
    input wire logic full_i,
    input wire logic popTransDone_i,
    input wire logic popData_i,
    input wire logic dataAvailable_i
);

    logic writeTaken, popTaken;

    assign writeTaken = dataValid_i && !full_i;
    assign popTaken   = popData_i && dataAvailable_i;

    // A commit or rollback owns the tentative write pointer for its cycle
    noWriteAtFillDone: assert property (
        @(posedge clk_i) disable iff (!rstN_i) !(fillTransDone_i && writeTaken)
    ) else $error("a write was accepted in the cycle that closed a fill transaction");

    // Same rule on the read side
    noPopAtPopDone: assert property (
        @(posedge clk_i) disable iff (!rstN_i) !(popTransDone_i && popTaken)
    ) else $error("a pop was accepted in the cycle that closed a pop transaction");

    quietAfterReset: assert property (
        @(posedge clk_i) $rose(rstN_i) |-> !fillTransDone_i && !popTransDone_i
    ) else $error("a transaction strobe was high in the first cycle after reset");

endmodule

bind transFifo pktBufTb_assert u_fifoAssert (
    .clk_i, .rstN_i, .fillTransDone_i, .dataValid_i, .full_i(full_o),
    .popTransDone_i, .popData_i, .dataAvailable_i(dataAvailable_o)
);

`default_nettype wire
